// ==== include/channel_sum_consts.svh ====
`ifndef CHANNEL_SUM_CONSTS_SVH
`define CHANNEL_SUM_CONSTS_SVH

////////////////////
// Stream geometry
////////////////////
`define CS_DATA_W     16
// Power of two, CS_CHAN_W is its log2
`define CS_CHANNELS   4
`define CS_CHAN_W     2
`define CS_MAX_PLANE  64
`define CS_PLANE_W    7

////////////////////
// APB register offsets
////////////////////
`define CS_REG_PLANE  4'h0
`define CS_REG_CTRL   4'h4
`define CS_REG_COUNT  4'h8
`define CS_REG_STATUS 4'hC

`endif

// ==== source/cs_stream_pkg.sv ====
`default_nettype none

`include "channel_sum_consts.svh"

package cs_stream_pkg;

  typedef logic signed [`CS_DATA_W-1:0] pixel_t;

  // Full precision over all channels, no wrap
  typedef logic signed [`CS_DATA_W+`CS_CHAN_W-1:0] sum_t;

  typedef logic [`CS_PLANE_W-1:0] pix_idx_t;
  typedef logic [`CS_CHAN_W-1:0]  chan_idx_t;

  typedef enum logic [1:0] {
    fr_idle,
    fr_fill,
    fr_sum
  } framer_state_t;

endpackage

`default_nettype wire

// ==== source/cs_apb_pkg.sv ====
`default_nettype none

package cs_apb_pkg;

  // Byte offsets of four word registers
  typedef logic [3:0] apb_addr_t;

  typedef logic [31:0] apb_data_t;

endpackage

`default_nettype wire

// ==== source/cs_apb_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "channel_sum_consts.svh"

module cs_apb_regs
  import cs_stream_pkg::*;
  import cs_apb_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      psel,
  input  wire logic      penable,
  input  wire logic      pwrite,
  input  wire apb_addr_t paddr,
  input  wire apb_data_t pwdata,
  input  wire logic      sum_valid,
  input  wire logic      overrun,
  output apb_data_t      prdata,
  output logic           pready,
  output logic           pslverr,
  output pix_idx_t       plane_size,
  output logic           enable
);

  logic      access;
  logic      wr_en;
  logic      sel_plane, sel_ctrl, sel_count, sel_status;
  logic      mapped;
  logic      plane_bad;
  logic      enable_rise;
  apb_data_t count;
  logic      overrun_flag;

  ////////////////////
  // Decode
  ////////////////////
  assign access     = psel & penable;
  assign sel_plane  = (paddr == `CS_REG_PLANE);
  assign sel_ctrl   = (paddr == `CS_REG_CTRL);
  assign sel_count  = (paddr == `CS_REG_COUNT);
  assign sel_status = (paddr == `CS_REG_STATUS);
  assign mapped     = sel_plane | sel_ctrl | sel_count | sel_status;

  // Plane size is fixed while the datapath runs
  assign plane_bad = pwrite & sel_plane &
                     ((pwdata == '0) || (pwdata > `CS_MAX_PLANE) || enable);

  assign pready      = 1'b1;
  assign pslverr     = access & (~mapped | plane_bad);
  assign wr_en       = access & pwrite & ~pslverr;
  assign enable_rise = wr_en & sel_ctrl & pwdata[0] & ~enable;

  ////////////////////
  // Registers
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      plane_size <= pix_idx_t'(`CS_MAX_PLANE);
      enable     <= 1'b0;
    end else if (wr_en) begin
      if (sel_plane) plane_size <= pwdata[`CS_PLANE_W-1:0];
      if (sel_ctrl)  enable     <= pwdata[0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset || enable_rise) begin
      count <= '0;
    end else if (sum_valid) begin
      count <= count + 1'b1;
    end
  end

  // Sticky, a new overrun wins over the clear
  always_ff @(posedge clk) begin
    if (reset) begin
      overrun_flag <= 1'b0;
    end else if (overrun) begin
      overrun_flag <= 1'b1;
    end else if (wr_en && sel_status && pwdata[0]) begin
      overrun_flag <= 1'b0;
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      `CS_REG_PLANE:  prdata    = apb_data_t'(plane_size);
      `CS_REG_CTRL:   prdata[0] = enable;
      `CS_REG_COUNT:  prdata    = count;
      `CS_REG_STATUS: prdata[0] = overrun_flag;
      default:        prdata    = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/cs_plane_framer.sv ====
`default_nettype none
`timescale 1ns/1ps

module cs_plane_framer
  import cs_stream_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     enable,
  input  wire pix_idx_t plane_size,
  input  wire logic     valid_in,
  input  wire pixel_t   pxl_in,
  output logic          shift,
  output pixel_t        tap_pxl,
  output logic          sum_en,
  output logic          overrun
);

  framer_state_t state;
  pix_idx_t      pix_idx;
  pix_idx_t      last_pix_idx;
  chan_idx_t     chan_idx;
  chan_idx_t     chan_nxt;
  logic          accept;
  logic          plane_end;
  logic          enter_last;

  assign accept       = valid_in & enable;
  assign last_pix_idx = plane_size - 1'b1;
  assign plane_end    = (pix_idx == last_pix_idx);
  assign chan_nxt     = chan_idx + 1'b1;
  // Next accepted pixel belongs to the last channel
  assign enter_last   = accept & plane_end & (chan_nxt == '1);

  // Position within the frame, held at zero while disabled
  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      state    <= fr_idle;
      pix_idx  <= '0;
      chan_idx <= '0;
    end else begin
      case (state)
        fr_idle, fr_fill: begin
          state <= enter_last ? fr_sum : fr_fill;
        end
        fr_sum: begin
          if (accept && plane_end) state <= fr_fill;
        end
        default: state <= fr_idle;
      endcase
      if (accept) begin
        pix_idx <= plane_end ? '0 : pix_idx + 1'b1;
        if (plane_end) chan_idx <= chan_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      shift   <= 1'b0;
      sum_en  <= 1'b0;
      overrun <= 1'b0;
    end else begin
      shift   <= accept;
      sum_en  <= accept & (state == fr_sum);
      overrun <= valid_in & ~enable;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) tap_pxl <= pxl_in;
  end

endmodule

`default_nettype wire

// ==== source/cs_plane_delay.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "channel_sum_consts.svh"

module cs_plane_delay
  import cs_stream_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     shift,
  input  wire pix_idx_t plane_size,
  input  wire pixel_t   din,
  output pixel_t        dout
);

  localparam int ADDR_W = $clog2(`CS_MAX_PLANE);

  pixel_t            mem [`CS_MAX_PLANE];
  pix_idx_t          wr_ptr;
  pix_idx_t          cur_ptr;
  pix_idx_t          last_slot;
  logic [ADDR_W-1:0] addr;

  // Pointer left over from a larger plane restarts at slot 0
  assign cur_ptr   = (wr_ptr >= plane_size) ? '0 : wr_ptr;
  assign last_slot = plane_size - 1'b1;
  assign addr      = cur_ptr[ADDR_W-1:0];

  // Oldest sample, read before this slot is overwritten
  assign dout = mem[addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (shift) begin
      wr_ptr <= (cur_ptr == last_slot) ? '0 : cur_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (shift) mem[addr] <= din;
  end

endmodule

`default_nettype wire

// ==== source/cs_adder_tree.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "channel_sum_consts.svh"

module cs_adder_tree
  import cs_stream_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire logic   valid_in,
  input  wire pixel_t taps [`CS_CHANNELS],
  output logic        valid_out,
  output sum_t        sum_out
);

  localparam int N      = `CS_CHANNELS;
  localparam int LEVELS = `CS_CHAN_W;

  // Heap layout, node 1 is the root and node j feeds on 2j and 2j+1
  sum_t            leaf [N];
  sum_t            node [1:N-1];
  logic [LEVELS:1] vld;

  genvar i, j;

  for (i = 0; i < N; i++) begin : g_leaf
    assign leaf[i] = sum_t'(taps[i]);
  end

  ////////////////////
  // Adder stages
  ////////////////////
  for (j = 1; j < N; j++) begin : g_node
    sum_t a;
    sum_t b;

    if (2 * j >= N) begin : g_from_leaf
      assign a = leaf[2 * j - N];
      assign b = leaf[2 * j + 1 - N];
    end else begin : g_from_node
      assign a = node[2 * j];
      assign b = node[2 * j + 1];
    end

    always_ff @(posedge clk) begin
      node[j] <= a + b;
    end
  end

  // One valid bit per registered stage
  always_ff @(posedge clk) begin
    if (reset) begin
      vld <= '0;
    end else begin
      vld[1] <= valid_in;
      for (int s = 2; s <= LEVELS; s++) begin
        vld[s] <= vld[s-1];
      end
    end
  end

  assign valid_out = vld[LEVELS];
  assign sum_out   = node[1];

endmodule

`default_nettype wire

// ==== source/channel_sum_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "channel_sum_consts.svh"

module channel_sum_top
  import cs_stream_pkg::*;
  import cs_apb_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  // APB
  input  wire logic      psel,
  input  wire logic      penable,
  input  wire logic      pwrite,
  input  wire apb_addr_t paddr,
  input  wire apb_data_t pwdata,
  output apb_data_t      prdata,
  output logic           pready,
  output logic           pslverr,
  // Pixel stream
  input  wire logic      valid_in,
  input  wire pixel_t    pxl_in,
  output logic           valid_out,
  output sum_t           sum_out
);

  pix_idx_t plane_size;
  logic     enable;
  logic     overrun;
  logic     shift;
  logic     sum_en;
  logic     tree_valid;
  pixel_t   taps [`CS_CHANNELS];

  ////////////////////
  // Control
  ////////////////////
  cs_apb_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .sum_valid  (valid_out),
    .overrun    (overrun),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .plane_size (plane_size),
    .enable     (enable)
  );

  // Tap 0 carries the newest channel
  cs_plane_framer u_framer (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .plane_size (plane_size),
    .valid_in   (valid_in),
    .pxl_in     (pxl_in),
    .shift      (shift),
    .tap_pxl    (taps[0]),
    .sum_en     (sum_en),
    .overrun    (overrun)
  );

  ////////////////////
  // Delay chain
  ////////////////////
  for (genvar i = 0; i < `CS_CHANNELS - 1; i++) begin : g_delay
    cs_plane_delay u_delay (
      .clk        (clk),
      .reset      (reset),
      .shift      (shift),
      .plane_size (plane_size),
      .din        (taps[i]),
      .dout       (taps[i+1])
    );
  end

  assign tree_valid = shift & sum_en;

  cs_adder_tree u_tree (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (tree_valid),
    .taps      (taps),
    .valid_out (valid_out),
    .sum_out   (sum_out)
  );

endmodule

`default_nettype wire

// ==== tests/channel_sum_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "channel_sum_consts.svh"

module channel_sum_tb
  import cs_stream_pkg::*;
  import cs_apb_pkg::*;
();

  localparam int CH          = `CS_CHANNELS;
  localparam int LATENCY     = 1 + `CS_CHAN_W;
  localparam int T1_FRAMES   = 3;
  localparam int T2_FRAMES   = 4;
  localparam int T2_PLANE    = 5;
  localparam int GAP_MAX     = 3;
  localparam int T5_PLANE    = 12;
  localparam int APB_OPS     = 40;
  localparam int STIM_CYCLES = 3 + T1_FRAMES * CH * `CS_MAX_PLANE
                               + T2_FRAMES * CH * T2_PLANE * (1 + GAP_MAX)
                               + 2 * CH * T2_PLANE + 2 * CH * T5_PLANE + 8
                               + APB_OPS * 3 + 10 * LATENCY;
  localparam int MAX_CYCLES  = 2 * STIM_CYCLES + 200;

  localparam int FILL_RANDOM = 0;
  localparam int FILL_MIN    = 1;
  localparam int FILL_MAX    = 2;
  localparam apb_addr_t UNMAPPED = 4'h2;

  logic      clk;
  logic      reset;
  logic      psel, penable, pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready, pslverr;
  logic      valid_in;
  pixel_t    pxl_in;
  logic      valid_out;
  sum_t      sum_out;

  integer    seed = 32'h3d886841;
  int        cycle = 0;
  string     test_name = "reset";
  int        test_errors = 0;
  int        total_errors = 0;
  int        tests_run = 0;
  int        tests_failed = 0;
  int        sums_seen = 0;
  int        sums_since_enable = 0;
  int        first;
  logic      tb_enabled;
  logic      err;
  apb_data_t rd;
  sum_t      exp_sum [$];
  int        exp_cycle [$];
  pixel_t    frame [CH][`CS_MAX_PLANE];

  channel_sum_top uut (
    .clk       (clk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .valid_in  (valid_in),
    .pxl_in    (pxl_in),
    .valid_out (valid_out),
    .sum_out   (sum_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    while (cycle < MAX_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // Pixel k of every channel in the current frame
  function automatic sum_t reference_sum(input int k);
    sum_t acc;
    acc = '0;
    for (int c = 0; c < CH; c++) acc = acc + sum_t'(frame[c][k]);
    return acc;
  endfunction

  task automatic check_equal(input string what, input longint expected, input longint actual);
    assert (expected == actual) else begin
      $display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  ////////////////////
  // Output checker
  ////////////////////
  always @(negedge clk) begin
    if (!reset) begin
      if (valid_out) begin
        assert (exp_sum.size() != 0) else begin
          $display("%s: a sum appeared with no last-channel pixel pending", test_name);
          test_errors++;
        end
        if (exp_sum.size() != 0) begin
          check_equal("sum", exp_sum.pop_front(), sum_out);
          check_equal("output cycle", exp_cycle.pop_front(), cycle);
        end
        sums_seen++;
        sums_since_enable++;
      end else if (exp_cycle.size() != 0) begin
        assert (cycle <= exp_cycle[0]) else begin
          $display("%s: expected sum did not appear by cycle %0d", test_name, exp_cycle[0]);
          test_errors++;
          void'(exp_sum.pop_front());
          void'(exp_cycle.pop_front());
        end
      end
    end
  end

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: passed", test_name);
    end else begin
      $display("%s: failed with %0d errors", test_name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
  endtask

  ////////////////////
  // APB access
  ////////////////////
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t data,
                            output apb_data_t rdata, output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    check_equal("pready", 1, pready);
    rdata  = prdata;
    slverr = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_expect(input apb_addr_t addr, input apb_data_t data,
                              input logic exp_err, input string what);
    apb_data_t unused;
    logic      slverr;
    apb_access(1'b1, addr, data, unused, slverr);
    check_equal({what, " pslverr"}, exp_err, slverr);
  endtask

  task automatic read_expect(input apb_addr_t addr, input longint expected, input string what);
    apb_data_t data;
    logic      slverr;
    apb_access(1'b0, addr, '0, data, slverr);
    check_equal(what, expected, data);
    check_equal({what, " pslverr"}, 0, slverr);
  endtask

  task automatic set_enable(input logic on);
    write_expect(`CS_REG_CTRL, apb_data_t'(on), 1'b0, "CTRL write");
    if (on && !tb_enabled) sums_since_enable = 0;
    tb_enabled = on;
  endtask

  ////////////////////
  // Pixel stream
  ////////////////////
  task automatic send_frame(input int size, input int mode, input int max_gap);
    int gap;
    for (int c = 0; c < CH; c++) begin
      for (int k = 0; k < size; k++) begin
        if (mode == FILL_MIN) frame[c][k] = {1'b1, {(`CS_DATA_W-1){1'b0}}};
        else if (mode == FILL_MAX) frame[c][k] = {1'b0, {(`CS_DATA_W-1){1'b1}}};
        else frame[c][k] = pixel_t'($random(seed));
      end
    end
    for (int c = 0; c < CH; c++) begin
      for (int k = 0; k < size; k++) begin
        gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
        repeat (gap) begin
          @(posedge clk);
          valid_in <= 1'b0;
        end
        @(posedge clk);
        valid_in <= 1'b1;
        pxl_in   <= frame[c][k];
        // Accepted in the cycle after this edge
        if (c == CH - 1) begin
          exp_sum.push_back(reference_sum(k));
          exp_cycle.push_back(cycle + 1 + LATENCY);
        end
      end
    end
  endtask

  task automatic stream_idle();
    @(posedge clk);
    valid_in <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_sum.size() != 0) @(posedge clk);
  endtask

  initial begin
    reset      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    valid_in   = 1'b0;
    pxl_in     = '0;
    tb_enabled = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    start_test("default_plane");
    first = sums_seen;
    set_enable(1'b1);
    repeat (T1_FRAMES) send_frame(`CS_MAX_PLANE, FILL_RANDOM, 0);
    stream_idle();
    wait_drain();
    check_equal("sum count", T1_FRAMES * `CS_MAX_PLANE, sums_seen - first);
    end_test();

    start_test("gapped_plane");
    set_enable(1'b0);
    write_expect(`CS_REG_PLANE, T2_PLANE, 1'b0, "PLANE_SIZE write");
    set_enable(1'b1);
    first = sums_seen;
    repeat (T2_FRAMES) send_frame(T2_PLANE, FILL_RANDOM, GAP_MAX);
    stream_idle();
    wait_drain();
    check_equal("sum count", T2_FRAMES * T2_PLANE, sums_seen - first);
    end_test();

    start_test("extreme_values");
    first = sums_seen;
    send_frame(T2_PLANE, FILL_MIN, 0);
    send_frame(T2_PLANE, FILL_MAX, 0);
    stream_idle();
    wait_drain();
    check_equal("sum count", 2 * T2_PLANE, sums_seen - first);
    end_test();

    start_test("apb_access");
    set_enable(1'b0);
    write_expect(`CS_REG_PLANE, 0, 1'b1, "PLANE_SIZE 0");
    write_expect(`CS_REG_PLANE, `CS_MAX_PLANE + 1, 1'b1, "PLANE_SIZE above max");
    read_expect(`CS_REG_PLANE, T2_PLANE, "PLANE_SIZE after rejects");
    write_expect(`CS_REG_PLANE, T5_PLANE, 1'b0, "PLANE_SIZE write");
    read_expect(`CS_REG_PLANE, T5_PLANE, "PLANE_SIZE readback");
    read_expect(`CS_REG_CTRL, 0, "CTRL readback");
    set_enable(1'b1);
    read_expect(`CS_REG_CTRL, 1, "CTRL readback");
    write_expect(`CS_REG_PLANE, 7, 1'b1, "PLANE_SIZE while enabled");
    read_expect(`CS_REG_PLANE, T5_PLANE, "PLANE_SIZE after enabled write");
    write_expect(UNMAPPED, 32'h1, 1'b1, "unmapped write");
    apb_access(1'b0, UNMAPPED, '0, rd, err);
    check_equal("unmapped read pslverr", 1, err);
    end_test();

    start_test("count_overrun");
    set_enable(1'b0);
    set_enable(1'b1);
    repeat (2) send_frame(T5_PLANE, FILL_RANDOM, 0);
    stream_idle();
    wait_drain();
    check_equal("sums since enable", 2 * T5_PLANE, sums_since_enable);
    read_expect(`CS_REG_COUNT, sums_since_enable, "COUNT");
    set_enable(1'b0);
    read_expect(`CS_REG_STATUS, 0, "STATUS before overrun");
    // Dropped pixels, the checker flags any output
    repeat (8) begin
      @(posedge clk);
      valid_in <= 1'b1;
      pxl_in   <= pixel_t'($random(seed));
    end
    stream_idle();
    repeat (LATENCY + 2) @(posedge clk);
    read_expect(`CS_REG_STATUS, 1, "STATUS after overrun");
    write_expect(`CS_REG_STATUS, 32'h1, 1'b0, "STATUS clear");
    read_expect(`CS_REG_STATUS, 0, "STATUS after clear");
    read_expect(`CS_REG_COUNT, 2 * T5_PLANE, "COUNT after dropped pixels");
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== channel_sum_top.f ====
+incdir+include
source/cs_stream_pkg.sv
source/cs_apb_pkg.sv
source/cs_apb_regs.sv
source/cs_plane_framer.sv
source/cs_plane_delay.sv
source/cs_adder_tree.sv
source/channel_sum_top.sv
tests/channel_sum_tb.sv

// ==== Makefile ====
# Verilator simulation of the channel sum subsystem

VERILATOR ?= verilator
TOP       ?= channel_sum_tb
FILELIST  ?= channel_sum_top.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= TEST PASS
VFLAGS    ?= --binary --assert --timing -Wno-fatal
EXTRA     ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR PASS_MSG VFLAGS EXTRA"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
